/* tb.f */
hw/ttc_pkg.sv
hw/ttc_regs.sv
hw/ttc_count_rst.sv
hw/ttc_prescaler.sv
hw/ttc_counter.sv
hw/ttc_top.sv
verif/tb_clkgen.sv
verif/ttc_tb.sv

/* Makefile */
# Verilator build and run of the timer testbench

all: run

# rebuilt only when the file list or a source changes
obj_dir/Vttc_tb: tb.f $(shell grep -v '^+' tb.f)
	verilator --binary --timing --assert -Wno-fatal --top-module ttc_tb -f tb.f -o Vttc_tb

# pass only when the log holds the pass line
run: obj_dir/Vttc_tb
	./obj_dir/Vttc_tb | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* verif/ttc_tb.sv */
// random tests of the timer slice against a cycle model with full-word accesses
// DUT built with PS_BITS = 4 and only prescale N of 0 to 3 is exercised
`timescale 1ns/10ps

module ttc_tb;

  import ttc_pkg::*;

  localparam int CLK_NS = 20;
  localparam int ROUNDS = 8;
  // upper cycle bounds per test
  localparam int T_REGS    = ROUNDS * 50;
  localparam int T_COUNT   = ROUNDS * 200;
  localparam int T_PRESC   = ROUNDS * 250;
  localparam int T_INTV    = 6 * 120;
  localparam int T_MATCH   = 4 * 120;
  localparam int T_RESTART = 4 * 120;
  localparam int WATCHDOG_NS =
    (T_REGS + T_COUNT + T_PRESC + T_INTV + T_MATCH + T_RESTART + 500) * CLK_NS;

  logic    pclk3;
  logic    n_p_reset3;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    irq;

  integer seed = 32'h0dec_d45a;
  int     cyc_cnt = 0;
  int     ack_cyc;
  int     n_pass = 0;
  int     n_fail = 0;
  int     test_fail;

  // register mirror and predicted count
  clk_ctrl_t  m_clk = '0;
  count_t     m_ctrl = '0;
  count_t     m_intv = '0;
  count_t     m_match = '0;
  count_t     m_count = '0;
  logic [1:0] m_sts = '0;
  logic [1:0] m_en = '0;

  tb_clkgen #(
    .PERIOD_NS  (CLK_NS),
    .RST_CYCLES (5)
  ) u_clkgen (
    .pclk3      (pclk3),
    .n_p_reset3 (n_p_reset3)
  );

  ttc_top #(
    .PS_BITS (4)
  ) DUT (
    .pclk3      (pclk3),
    .n_p_reset3 (n_p_reset3),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .irq        (irq)
  );

  // rising edge counter sampled on falling edges
  always @(posedge pclk3)
    cyc_cnt <= cyc_cnt + 1;

  // --------------------
  // helpers
  // --------------------

  function automatic count_t rand16();
    rand16 = count_t'($random(seed));
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    rand_range = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // down in interval mode starts from interval
  function automatic count_t start_value(input count_t ctrl, input count_t intv);
    start_value = (ctrl[CTRL_INTV] && ctrl[CTRL_DEC]) ? intv : '0;
  endfunction

  // one counter step
  function automatic count_t model_step(input count_t c, input count_t ctrl,
                                        input count_t intv, output logic wrapped);
    count_t nxt;
    begin
      wrapped = 1'b0;
      if (ctrl[CTRL_INTV])
      begin
        if (!ctrl[CTRL_DEC] && c == intv)
        begin
          nxt     = '0;
          wrapped = 1'b1;
        end
        else if (ctrl[CTRL_DEC] && c == '0)
        begin
          nxt     = intv;
          wrapped = 1'b1;
        end
        else
          nxt = ctrl[CTRL_DEC] ? c - 1'b1 : c + 1'b1;
      end
      else
      begin
        // free running with a full 16-bit wrap
        nxt     = ctrl[CTRL_DEC] ? c - 1'b1 : c + 1'b1;
        wrapped = ctrl[CTRL_DEC] ? (c == 16'h0000) : (c == 16'hffff);
      end
      return nxt;
    end
  endfunction

  task automatic check_val(input string what, input count_t exp, input count_t act);
    logic ok;
    begin
      ok = (act === exp);
      assert (ok)
      else
      begin
        $display("Mismatch at %0d ns: %s expected %h, got %h", $time, what, exp, act);
        n_fail++;
      end
      if (ok)
        n_pass++;
    end
  endtask

  task automatic report_test(input string name);
    begin
      if (n_fail == test_fail)
        $display("test %s: pass", name);
      else
        $display("test %s: FAIL with %0d errors", name, n_fail - test_fail);
    end
  endtask

  // --------------------
  // bus access
  // --------------------

  // entered on a falling edge and left on the falling edge after ack
  task automatic wait_ack(input wb_adr_t adr);
    int n;
    begin
      n = 0;
      @(negedge pclk3);
      while (!wb_rsp.ack && n < 16)
      begin
        @(negedge pclk3);
        n++;
      end
      if (!wb_rsp.ack)
      begin
        $display("Error at %0d ns: the DUT never acked an access to address %0d", $time, adr);
        n_fail++;
      end
      ack_cyc = cyc_cnt;
    end
  endtask

  task automatic reg_write(input wb_adr_t adr, input count_t dat);
    begin
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = 1'b1;
      wb_req.adr = adr;
      wb_req.dat = dat;
      wait_ack(adr);
      wb_req = '0;
      // restart bit is never stored in the mirror
      case (adr)
        REG_CLK_CTRL: m_clk   = dat[6:0];
        REG_CNT_CTRL: m_ctrl  = dat & 16'h000f;
        REG_INTERVAL: m_intv  = dat;
        REG_MATCH:    m_match = dat;
        REG_IRQ_STS:  m_sts   = m_sts & ~dat[1:0];
        REG_IRQ_EN:   m_en    = dat[1:0];
        default:      ;
      endcase
    end
  endtask

  task automatic reg_read(input wb_adr_t adr, output count_t dat);
    begin
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = 1'b0;
      wb_req.adr = adr;
      wb_req.dat = '0;
      wait_ack(adr);
      dat    = wb_rsp.dat;
      wb_req = '0;
    end
  endtask

  task automatic read_check(input wb_adr_t adr, input count_t exp, input string what);
    count_t got;
    begin
      reg_read(adr, got);
      check_val(what, exp, got);
    end
  endtask

  // --------------------
  // counting run
  // --------------------

  // restart while disabled then run for wait_cyc cycles and predict count and events
  task automatic run_count(input count_t mode, input int wait_cyc);
    int     e3;
    int     ce;
    int     e;
    int     per;
    logic   wrapped;
    count_t c;
    begin
      reg_write(REG_CNT_CTRL, mode | count_t'(1 << CTRL_DIS) | count_t'(1 << CTRL_RST));
      // reload and divider clear two edges after the restart ack
      e3 = ack_cyc + 2;
      reg_write(REG_CNT_CTRL, mode);
      ce = ack_cyc;
      repeat (wait_cyc) @(negedge pclk3);
      reg_write(REG_CNT_CTRL, mode | count_t'(1 << CTRL_DIS));
      per = m_clk[CLK_PS_EN] ? (2 << m_clk[4:1]) : 1;
      c   = start_value(mode, m_intv);
      // disabling write still steps at its own ack edge
      for (e = ((ce > e3) ? ce : e3) + 1; e <= ack_cyc; e++)
      begin
        if ((e - e3) % per == 0)
        begin
          c = model_step(c, mode, m_intv, wrapped);
          if (wrapped)
            m_sts[IRQ_INTV] = 1'b1;
          if (mode[CTRL_MATCH] && c == m_match)
            m_sts[IRQ_MATCH] = 1'b1;
        end
      end
      m_count = c;
    end
  endtask

  // --------------------
  // tests
  // --------------------

  initial
  begin
    int     i;
    int     k;
    count_t mode;
    wb_req = '0;
    @(posedge n_p_reset3);
    @(negedge pclk3);

    // register readback
    test_fail = n_fail;
    for (i = 0; i < ROUNDS; i++)
    begin
      reg_write(REG_CLK_CTRL, rand16());
      reg_write(REG_CNT_CTRL, rand16());
      reg_write(REG_INTERVAL, rand16());
      reg_write(REG_MATCH, rand16());
      reg_write(REG_IRQ_EN, rand16());
      reg_write(REG_RSVD, rand16());
      read_check(REG_CLK_CTRL, count_t'(m_clk), "clock control");
      read_check(REG_CNT_CTRL, m_ctrl, "counter control");
      read_check(REG_INTERVAL, m_intv, "interval");
      read_check(REG_MATCH, m_match, "match");
      read_check(REG_IRQ_EN, count_t'(m_en), "interrupt enable");
      read_check(REG_RSVD, '0, "address 7");
    end
    // stop counting, then drop stray events
    reg_write(REG_CNT_CTRL, count_t'(1 << CTRL_DIS));
    reg_write(REG_IRQ_STS, 16'h0003);
    report_test("register readback");

    // free running up and down with a tick in every enabled cycle
    test_fail = n_fail;
    reg_write(REG_CLK_CTRL, 16'h0000);
    for (i = 0; i < ROUNDS; i++)
    begin
      mode = (i % 2) ? count_t'(1 << CTRL_DEC) : '0;
      run_count(mode, rand_range(0, 150));
      read_check(REG_COUNT, m_count, "count, prescaler off");
    end
    report_test("count with prescaler off");

    // prescale N of 0 to 3 over up to 12 periods
    test_fail = n_fail;
    for (i = 0; i < ROUNDS; i++)
    begin
      k = rand_range(0, 3);
      reg_write(REG_CLK_CTRL, count_t'((k << CLK_PS_LSB) | 1));
      mode = rand16() & count_t'(1 << CTRL_DEC);
      run_count(mode, rand_range(0, 12 << (k + 1)));
      read_check(REG_COUNT, m_count, "count, prescaler on");
    end
    report_test("prescale division");

    // interval wrap both ways and irq gating by enable
    test_fail = n_fail;
    reg_write(REG_CLK_CTRL, 16'h0000);
    for (i = 0; i < 6; i++)
    begin
      reg_write(REG_IRQ_EN, 16'h0000);
      reg_write(REG_IRQ_STS, 16'h0003);
      reg_write(REG_INTERVAL, count_t'(rand_range(1, 7)));
      mode = count_t'(1 << CTRL_INTV) | ((i % 2) ? count_t'(1 << CTRL_DEC) : '0);
      run_count(mode, rand_range(20, 60));
      read_check(REG_COUNT, m_count, "count, interval mode");
      read_check(REG_IRQ_STS, count_t'(m_sts), "interrupt status");
      check_val("irq, enable clear", count_t'(|(m_sts & m_en)), count_t'(irq));
      reg_write(REG_IRQ_EN, count_t'(1 << IRQ_INTV));
      check_val("irq, enable set", count_t'(|(m_sts & m_en)), count_t'(irq));
      reg_write(REG_IRQ_STS, count_t'(1 << IRQ_INTV));
      check_val("irq after clear", count_t'(|(m_sts & m_en)), count_t'(irq));
      read_check(REG_IRQ_STS, count_t'(m_sts), "interrupt status after clear");
    end
    report_test("interval wrap and interrupt");

    // match below the step count with compare on and off
    test_fail = n_fail;
    for (i = 0; i < 4; i++)
    begin
      reg_write(REG_IRQ_STS, 16'h0003);
      reg_write(REG_MATCH, count_t'(rand_range(1, 15)));
      mode = (i % 2) ? '0 : count_t'(1 << CTRL_MATCH);
      run_count(mode, rand_range(20, 60));
      read_check(REG_IRQ_STS, count_t'(m_sts), "interrupt status, match");
    end
    report_test("match");

    // second restart while counting that also disables
    test_fail = n_fail;
    for (i = 0; i < 4; i++)
    begin
      reg_write(REG_INTERVAL, count_t'(rand_range(100, 1000)));
      mode = rand16() & (count_t'(1 << CTRL_INTV) | count_t'(1 << CTRL_DEC));
      run_count(mode, rand_range(10, 40));
      reg_write(REG_CNT_CTRL, mode);
      repeat (rand_range(5, 30)) @(negedge pclk3);
      reg_write(REG_CNT_CTRL, mode | count_t'(1 << CTRL_DIS) | count_t'(1 << CTRL_RST));
      m_count = start_value(m_ctrl, m_intv);
      // reload lands two edges after the restart ack
      repeat (2) @(negedge pclk3);
      read_check(REG_COUNT, m_count, "count after restart");
    end
    report_test("repeated restart");

    $display("checks passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // watchdog over the summed test budgets
  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

endmodule

/* verif/tb_clkgen.sv */
// testbench clock and reset, reset low for RST_CYCLES then released on a falling edge
`timescale 1ns/10ps

module tb_clkgen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 5
) (
  output logic pclk3,
  output logic n_p_reset3
);

  initial
  begin
    pclk3 = 1'b0;
    forever
      #(PERIOD_NS / 2) pclk3 = ~pclk3;
  end

  // released away from the rising edge
  initial
  begin
    n_p_reset3 = 1'b0;
    repeat (RST_CYCLES) @(posedge pclk3);
    @(negedge pclk3);
    n_p_reset3 = 1'b1;
  end

endmodule

/* hw/ttc_top.sv */
// single-channel timer slice, wishbone classic register port and one interrupt
// no external clock source and no waveform output
`timescale 1ns/10ps

module ttc_top #(
  parameter int PS_BITS = 4
) (
  input  logic             pclk3,
  input  logic             n_p_reset3,
  input  ttc_pkg::wb_req_t wb_req,
  output ttc_pkg::wb_rsp_t wb_rsp,
  output logic             irq
);

  import ttc_pkg::*;

  logic      clk_ctrl_sel;
  clk_ctrl_t clk_ctrl_wdata;
  clk_ctrl_t clk_ctrl;
  logic      restart;
  logic      count_en;
  logic      tick;
  count_t    cnt_ctrl;
  count_t    interval;
  count_t    match;
  count_t    count;
  logic      ev_intv;
  logic      ev_match;

  // register block
  ttc_regs u_regs (
    .pclk3          (pclk3),
    .n_p_reset3     (n_p_reset3),
    .wb_req         (wb_req),
    .wb_rsp         (wb_rsp),
    .clk_ctrl       (clk_ctrl),
    .count          (count),
    .ev_intv        (ev_intv),
    .ev_match       (ev_match),
    .clk_ctrl_sel   (clk_ctrl_sel),
    .clk_ctrl_wdata (clk_ctrl_wdata),
    .restart        (restart),
    .cnt_ctrl       (cnt_ctrl),
    .interval       (interval),
    .match          (match),
    .irq            (irq)
  );

  // clock control and restart enable
  ttc_count_rst #(
    .PS_BITS (PS_BITS)
  ) u_count_rst (
    .pclk3          (pclk3),
    .n_p_reset3     (n_p_reset3),
    .clk_ctrl_sel   (clk_ctrl_sel),
    .clk_ctrl_wdata (clk_ctrl_wdata),
    .restart        (restart),
    .clk_ctrl       (clk_ctrl),
    .count_en       (count_en)
  );

  ttc_prescaler #(
    .PS_BITS (PS_BITS)
  ) u_prescaler (
    .pclk3      (pclk3),
    .n_p_reset3 (n_p_reset3),
    .clk_ctrl   (clk_ctrl),
    .count_en   (count_en),
    .tick       (tick)
  );

  ttc_counter u_counter (
    .pclk3      (pclk3),
    .n_p_reset3 (n_p_reset3),
    .count_en   (count_en),
    .tick       (tick),
    .cnt_ctrl   (cnt_ctrl),
    .interval   (interval),
    .match      (match),
    .count      (count),
    .ev_intv    (ev_intv),
    .ev_match   (ev_match)
  );

endmodule

/* hw/ttc_counter.sv */
// 16-bit up/down counter with interval reload and match compare
// start value is interval only for down counting in interval mode, else zero
`timescale 1ns/10ps

module ttc_counter (
  input  logic            pclk3,
  input  logic            n_p_reset3,
  input  logic            count_en,
  input  logic            tick,
  input  ttc_pkg::count_t cnt_ctrl,
  input  ttc_pkg::count_t interval,
  input  ttc_pkg::count_t match,
  output ttc_pkg::count_t count,
  output logic            ev_intv,
  output logic            ev_match
);

  import ttc_pkg::*;

  logic   dec;
  logic   intv_mode;
  logic   step;
  logic   wrap;
  count_t start_val;
  count_t count_nxt;

  assign dec       = cnt_ctrl[CTRL_DEC];
  assign intv_mode = cnt_ctrl[CTRL_INTV];
  assign step      = tick & ~cnt_ctrl[CTRL_DIS];

  assign start_val = (intv_mode && dec) ? interval : '0;

  // --------------------
  // next count
  // --------------------

  always_comb
  begin
    wrap      = 1'b0;
    count_nxt = count;
    if (intv_mode && !dec)
    begin
      // past interval also wraps, in case interval shrank
      if (count >= interval)
      begin
        count_nxt = '0;
        wrap      = 1'b1;
      end
      else
        count_nxt = count + 1'b1;
    end
    else if (intv_mode)
    begin
      if (count == '0)
      begin
        count_nxt = interval;
        wrap      = 1'b1;
      end
      else
        count_nxt = count - 1'b1;
    end
    else if (dec)
    begin
      // free running down, 0 to ffff
      count_nxt = count - 1'b1;
      wrap      = (count == '0);
    end
    else
    begin
      count_nxt = count + 1'b1;
      wrap      = (count == '1);
    end
  end

  // --------------------
  // count and events
  // --------------------

  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin
    if (!n_p_reset3)
    begin
      count    <= '0;
      ev_intv  <= 1'b0;
      ev_match <= 1'b0;
    end
    else if (!count_en)
    begin
      // restart cycle, reload
      count    <= start_val;
      ev_intv  <= 1'b0;
      ev_match <= 1'b0;
    end
    else
    begin
      if (step)
        count <= count_nxt;
      ev_intv  <= step & wrap;
      ev_match <= step & cnt_ctrl[CTRL_MATCH] & (count_nxt == match);
    end
  end

endmodule

/* hw/ttc_prescaler.sv */
// count tick generator, divides by 2^(N+1) or passes every enabled cycle
// divider is cleared while count_en is low, so the first tick is a full period late
`timescale 1ns/10ps

module ttc_prescaler #(
  parameter int PS_BITS = 4
) (
  input  logic               pclk3,
  input  logic               n_p_reset3,
  input  ttc_pkg::clk_ctrl_t clk_ctrl,
  input  logic               count_en,
  output logic               tick
);

  import ttc_pkg::*;

  // largest period is 2^(2^PS_BITS)
  localparam int DIV_W = 1 << PS_BITS;

  logic [DIV_W-1:0]   div;
  logic [DIV_W-1:0]   div_mask;
  logic [PS_BITS-1:0] ps_n;
  logic [PS_BITS:0]   ps_shift;
  logic               ps_en;

  assign ps_en    = clk_ctrl[CLK_PS_EN];
  assign ps_n     = clk_ctrl[CLK_PS_LSB +: PS_BITS];
  // one extra bit so N+1 never wraps
  assign ps_shift = {1'b0, ps_n} + 1'b1;

  // low N+1 bits set
  assign div_mask = ~({DIV_W{1'b1}} << ps_shift);

  // free-running divider
  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin
    if (!n_p_reset3)
    begin
      div <= '0;
    end
    else if (!count_en)
    begin
      div <= '0;
    end
    else
    begin
      div <= div + 1'b1;
    end
  end

  // tick in the last cycle of each period
  assign tick = count_en & (!ps_en || ((div & div_mask) == div_mask));

endmodule

/* hw/ttc_count_rst.sv */
// clock control register and restart handling, count_en drops one cycle per restart
`timescale 1ns/10ps

module ttc_count_rst #(
  parameter int PS_BITS = 4
) (
  input  logic               pclk3,
  input  logic               n_p_reset3,
  input  logic               clk_ctrl_sel,
  input  ttc_pkg::clk_ctrl_t clk_ctrl_wdata,
  input  logic               restart,
  output ttc_pkg::clk_ctrl_t clk_ctrl,
  output logic               count_en
);

  import ttc_pkg::*;

  // prescale bits beyond PS_BITS are reserved and stay zero
  localparam clk_ctrl_t PS_MASK = clk_ctrl_t'(((1 << PS_BITS) - 1) << CLK_PS_LSB);
  localparam clk_ctrl_t WR_MASK = 7'h61 | PS_MASK;

  logic restart_seen;

  // clock control, loaded on the write strobe
  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin
    if (!n_p_reset3)
    begin
      clk_ctrl <= '0;
    end
    else if (clk_ctrl_sel)
    begin
      clk_ctrl <= clk_ctrl_wdata & WR_MASK;
    end
  end

  // --------------------
  // restart
  // --------------------

  // first restart cycle drops count_en, a held level is ignored
  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin
    if (!n_p_reset3)
    begin
      restart_seen <= 1'b0;
      count_en     <= 1'b0;
    end
    else if (restart && !restart_seen)
    begin
      restart_seen <= 1'b1;
      count_en     <= 1'b0;
    end
    else
    begin
      // rearm once restart falls
      if (!restart)
        restart_seen <= 1'b0;
      count_en <= 1'b1;
    end
  end

endmodule

/* hw/ttc_regs.sv */
// wishbone classic register slave, one ack per request, master does the back-pressure
// clock control lives in ttc_count_rst, only its write strobe and readback pass here
`timescale 1ns/10ps

module ttc_regs (
  input  logic             pclk3,
  input  logic             n_p_reset3,
  input  ttc_pkg::wb_req_t wb_req,
  output ttc_pkg::wb_rsp_t wb_rsp,
  input  ttc_pkg::clk_ctrl_t clk_ctrl,
  input  ttc_pkg::count_t  count,
  input  logic             ev_intv,
  input  logic             ev_match,
  output logic             clk_ctrl_sel,
  output ttc_pkg::clk_ctrl_t clk_ctrl_wdata,
  output logic             restart,
  output ttc_pkg::count_t  cnt_ctrl,
  output ttc_pkg::count_t  interval,
  output ttc_pkg::count_t  match,
  output logic             irq
);

  import ttc_pkg::*;

  logic      req;
  logic      acc;
  logic      wr_en;
  reg_addr_e addr;
  logic      ack_q;
  count_t    rdata_q;
  count_t    rd_mux;
  logic [3:0] ctrl_q;
  logic [1:0] irq_sts;
  logic [1:0] irq_en;
  logic [1:0] w1c;
  logic [1:0] ev;

  // --------------------
  // bus handshake
  // --------------------

  assign req  = wb_req.cyc & wb_req.stb;
  assign addr = reg_addr_e'(wb_req.adr);

  // access is accepted in the cycle before ack rises
  assign acc   = req & ~ack_q;
  assign wr_en = acc & wb_req.we;

  // ack high one cycle, a held stb gets the next ack two cycles on
  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin
    if (!n_p_reset3)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= acc;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rdata_q;

  // --------------------
  // write decode
  // --------------------

  // clock control strobe, loads next door at the ack edge
  assign clk_ctrl_sel   = wr_en & (addr == REG_CLK_CTRL);
  assign clk_ctrl_wdata = wb_req.dat[6:0];

  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin
    if (!n_p_reset3)
    begin
      ctrl_q   <= '0;
      interval <= '0;
      match    <= '0;
      irq_en   <= '0;
      restart  <= 1'b0;
    end
    else
    begin
      // restart bit is only a pulse, high with ack
      restart <= wr_en & (addr == REG_CNT_CTRL) & wb_req.dat[CTRL_RST];
      if (wr_en)
      begin
        case (addr)
          REG_CNT_CTRL: ctrl_q   <= wb_req.dat[CTRL_MATCH:CTRL_DIS];
          REG_INTERVAL: interval <= wb_req.dat;
          REG_MATCH:    match    <= wb_req.dat;
          REG_IRQ_EN:   irq_en   <= wb_req.dat[IRQ_MATCH:IRQ_INTV];
          default:      ;
        endcase
      end
    end
  end

  // stored control bits, upper bits read as zero
  assign cnt_ctrl = count_t'(ctrl_q);

  // --------------------
  // interrupt status
  // --------------------

  assign w1c = (wr_en && addr == REG_IRQ_STS) ? wb_req.dat[IRQ_MATCH:IRQ_INTV] : 2'b00;

  always_comb
  begin
    ev            = '0;
    ev[IRQ_INTV]  = ev_intv;
    ev[IRQ_MATCH] = ev_match;
  end

  // a new event wins over a clear in the same cycle
  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin
    if (!n_p_reset3)
    begin
      irq_sts <= '0;
    end
    else
    begin
      irq_sts <= (irq_sts & ~w1c) | ev;
    end
  end

  assign irq = |(irq_sts & irq_en);

  // --------------------
  // read path
  // --------------------

  always_comb
  begin
    case (addr)
      REG_CLK_CTRL: rd_mux = count_t'(clk_ctrl);
      REG_CNT_CTRL: rd_mux = cnt_ctrl;
      REG_COUNT:    rd_mux = count;
      REG_INTERVAL: rd_mux = interval;
      REG_MATCH:    rd_mux = match;
      REG_IRQ_STS:  rd_mux = count_t'(irq_sts);
      REG_IRQ_EN:   rd_mux = count_t'(irq_en);
      REG_RSVD:     rd_mux = '0;
      default:      rd_mux = '0;
    endcase
  end

  // sampled at the ack edge, held while ack is high
  always_ff @(posedge pclk3 or negedge n_p_reset3)
  begin
    if (!n_p_reset3)
    begin
      rdata_q <= '0;
    end
    else if (acc && !wb_req.we)
    begin
      rdata_q <= rd_mux;
    end
  end

endmodule

/* hw/ttc_pkg.sv */
// shared types for the single-channel timer slice
// bus data is always a full 16-bit word, there are no byte selects

package ttc_pkg;

  // --------------------
  // widths
  // --------------------

  // count, interval, match and bus data
  typedef logic [15:0] count_t;

  // clock control register
  //   bit 0     prescale enable
  //   bits 4:1  prescale value N, tick every 2^(N+1) cycles
  //   bits 6:5  reserved, stored and read back only
  typedef logic [6:0] clk_ctrl_t;

  // word address on the register port
  typedef logic [2:0] wb_adr_t;

  // --------------------
  // register map
  // --------------------

  typedef enum wb_adr_t {
    REG_CLK_CTRL = 3'd0,
    REG_CNT_CTRL = 3'd1,
    // read-only, writes ignored
    REG_COUNT    = 3'd2,
    REG_INTERVAL = 3'd3,
    REG_MATCH    = 3'd4,
    // write one to clear
    REG_IRQ_STS  = 3'd5,
    REG_IRQ_EN   = 3'd6,
    REG_RSVD     = 3'd7
  } reg_addr_e;

  // clock control fields
  localparam int CLK_PS_EN  = 0;
  localparam int CLK_PS_LSB = 1;

  // counter control bits
  localparam int CTRL_DIS   = 0;
  localparam int CTRL_INTV  = 1;
  localparam int CTRL_DEC   = 2;
  localparam int CTRL_MATCH = 3;
  // restart, pulse only and never stored
  localparam int CTRL_RST   = 4;

  // interrupt status and enable bits
  localparam int IRQ_INTV  = 0;
  localparam int IRQ_MATCH = 1;

  // --------------------
  // wishbone classic
  // --------------------

  // master to slave
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    count_t  dat;
  } wb_req_t;

  // slave to master, dat valid while ack is high
  typedef struct packed {
    logic   ack;
    count_t dat;
  } wb_rsp_t;

endpackage
